// ==== logic/mem_pkg.sv ====
// Memory-stage constants: internal opcodes, channel codes and address decode
// Only the low 32 address bits take part in the region decode
package mem_pkg;

  localparam int xlen     = 64;
  localparam int ridx_w   = 5;
  localparam int opcode_w = 8;
  localparam int chan_w   = 2;
  // access size is encoded as bytes minus one
  localparam int bytes_w  = 3;

  // internal opcodes, anything else is a non-memory instruction
  localparam logic [opcode_w-1:0] op_lb     = 8'h10;
  localparam logic [opcode_w-1:0] op_lbu    = 8'h11;
  localparam logic [opcode_w-1:0] op_lh     = 8'h12;
  localparam logic [opcode_w-1:0] op_lhu    = 8'h13;
  localparam logic [opcode_w-1:0] op_lw     = 8'h14;
  localparam logic [opcode_w-1:0] op_lwu    = 8'h15;
  localparam logic [opcode_w-1:0] op_ld     = 8'h16;
  localparam logic [opcode_w-1:0] op_sb     = 8'h18;
  localparam logic [opcode_w-1:0] op_sh     = 8'h19;
  localparam logic [opcode_w-1:0] op_sw     = 8'h1a;
  localparam logic [opcode_w-1:0] op_sd     = 8'h1b;
  localparam logic [opcode_w-1:0] op_fencei = 8'h20;

  // channel codes
  localparam logic [chan_w-1:0] chan_none  = 2'd0;
  localparam logic [chan_w-1:0] chan_mem   = 2'd1;
  localparam logic [chan_w-1:0] chan_clint = 2'd2;
  localparam logic [chan_w-1:0] chan_sync  = 2'd3;

  // memory when any of addr[31:28] is set
  localparam logic [31:0] mem_region_hi = 32'hf000_0000;

  // mmio when addr[31:24] matches
  localparam logic [7:0] mmio_prefix = 8'h02;

endpackage

// ==== logic/clint_pkg.sv ====
// CLINT register map and reset values
// Addresses are matched on the low 32 bits only
package clint_pkg;

  localparam logic [31:0] clint_mtimecmp_addr = 32'h0200_4000;
  localparam logic [31:0] clint_mtime_addr    = 32'h0200_bff8;

  // compare never fires until software programs it
  localparam logic [63:0] clint_mtimecmp_reset = 64'hffff_ffff_ffff_ffff;

endpackage

// ==== logic/mem_addr_gen.sv ====
// Load/store decode and channel select, purely combinational
// Misaligned accesses are not detected; data sits right-aligned at bit 0
`timescale 1ns/1ps

module mem_addr_gen import mem_pkg::*; (
  input  logic [opcode_w-1:0] i_opcode,
  input  logic [xlen-1:0]     i_op1,
  input  logic [xlen-1:0]     i_op2,
  input  logic [xlen-1:0]     i_op3,
  output logic [xlen-1:0]     o_addr,
  output logic [bytes_w-1:0]  o_bytes,
  output logic                o_ren,
  output logic                o_wen,
  output logic [xlen-1:0]     o_wdata,
  output logic [chan_w-1:0]   o_chan
);

  logic addr_is_mem;
  logic addr_is_mmio;

  assign o_addr = i_op1 + i_op3;

  assign addr_is_mem  = (o_addr[31:0] & mem_region_hi) != 32'd0;
  assign addr_is_mmio = o_addr[31:24] == mmio_prefix;

  always_comb begin
    o_ren   = 1'b0;
    o_wen   = 1'b0;
    o_bytes = 3'd0;
    o_wdata = '0;
    case (i_opcode)
      op_lb, op_lbu: begin
        o_ren = 1'b1;
      end
      op_lh, op_lhu: begin
        o_ren   = 1'b1;
        o_bytes = 3'd1;
      end
      op_lw, op_lwu: begin
        o_ren   = 1'b1;
        o_bytes = 3'd3;
      end
      op_ld: begin
        o_ren   = 1'b1;
        o_bytes = 3'd7;
      end
      op_sb: begin
        o_wen   = 1'b1;
        o_wdata = {56'd0, i_op2[7:0]};
      end
      op_sh: begin
        o_wen   = 1'b1;
        o_bytes = 3'd1;
        o_wdata = {48'd0, i_op2[15:0]};
      end
      op_sw: begin
        o_wen   = 1'b1;
        o_bytes = 3'd3;
        o_wdata = {32'd0, i_op2[31:0]};
      end
      op_sd: begin
        o_wen   = 1'b1;
        o_bytes = 3'd7;
        o_wdata = i_op2;
      end
      default: begin
      end
    endcase
  end

  // fence.i wins regardless of address
  always_comb begin
    if (i_opcode == op_fencei) begin
      o_chan = chan_sync;
    end else if ((o_ren || o_wen) && addr_is_mem) begin
      o_chan = chan_mem;
    end else if ((o_ren || o_wen) && addr_is_mmio) begin
      o_chan = chan_clint;
    end else begin
      o_chan = chan_none;
    end
  end

endmodule

// ==== logic/mem_dcache_port.sv ====
// Single-request sequencer toward the data cache
// i_start must not arrive while a request is outstanding
`timescale 1ns/1ps

module mem_dcache_port import mem_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_start,
  input  logic [xlen-1:0]    i_addr,
  input  logic [bytes_w-1:0] i_bytes,
  input  logic               i_wen,
  input  logic [xlen-1:0]    i_wdata,
  input  logic               i_dcache_ack,
  input  logic [xlen-1:0]    i_dcache_rdata,
  output logic               o_done,
  output logic [xlen-1:0]    o_rdata,
  output logic               o_dcache_req,
  output logic [xlen-1:0]    o_dcache_addr,
  output logic               o_dcache_op,
  output logic [bytes_w-1:0] o_dcache_bytes,
  output logic [xlen-1:0]    o_dcache_wdata
);

  logic ack_seen;

  assign ack_seen = o_dcache_req && i_dcache_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_dcache_req <= 1'b0;
      o_done       <= 1'b0;
    end else begin
      o_done <= ack_seen;
      if (i_start) begin
        o_dcache_req <= 1'b1;
      end else if (ack_seen) begin
        o_dcache_req <= 1'b0;
      end
    end
  end

  // request fields, stable while req is up
  always_ff @(posedge clk) begin
    if (i_start) begin
      o_dcache_addr  <= i_addr;
      o_dcache_op    <= i_wen;
      o_dcache_bytes <= i_bytes;
      o_dcache_wdata <= i_wdata;
    end
  end

  // read data is only valid on the ack cycle
  always_ff @(posedge clk) begin
    if (ack_seen) begin
      o_rdata <= i_dcache_rdata;
    end
  end

endmodule

// ==== logic/mem_clint.sv ====
// Core-local timer: free-running mtime and writable mtimecmp
// Unmapped addresses read as zero and ignore writes
`timescale 1ns/1ps

module mem_clint
  import mem_pkg::*;
  import clint_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic [xlen-1:0] i_addr,
  input  logic            i_ren,
  input  logic            i_wen,
  input  logic [xlen-1:0] i_wdata,
  output logic [xlen-1:0] o_rdata,
  output logic            o_overflow
);

  logic [xlen-1:0] mtime;
  logic [xlen-1:0] mtimecmp;
  logic            sel_mtime;
  logic            sel_mtimecmp;
  logic            wr_mtime;
  logic            wr_mtimecmp;

  assign sel_mtime    = i_addr[31:0] == clint_mtime_addr;
  assign sel_mtimecmp = i_addr[31:0] == clint_mtimecmp_addr;

  assign wr_mtime    = i_start && i_wen && sel_mtime;
  assign wr_mtimecmp = i_start && i_wen && sel_mtimecmp;

  // a write replaces this cycle's increment
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else if (wr_mtime) begin
      mtime <= i_wdata;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp <= clint_mtimecmp_reset;
    end else if (wr_mtimecmp) begin
      mtimecmp <= i_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start && i_ren) begin
      if (sel_mtime) begin
        o_rdata <= mtime;
      end else if (sel_mtimecmp) begin
        o_rdata <= mtimecmp;
      end else begin
        o_rdata <= '0;
      end
    end
  end

  // level, stays up until mtimecmp moves past mtime
  assign o_overflow = mtime >= mtimecmp;

endmodule

// ==== logic/mem_load_align.sv ====
// Load extension and writeback value select
// Non-load opcodes return the upstream writeback value unchanged
`timescale 1ns/1ps

module mem_load_align import mem_pkg::*; (
  input  logic [opcode_w-1:0] i_opcode,
  input  logic [chan_w-1:0]   i_chan,
  input  logic [xlen-1:0]     i_mem_rdata,
  input  logic [xlen-1:0]     i_clint_rdata,
  input  logic [xlen-1:0]     i_rd_wdata,
  output logic [xlen-1:0]     o_rd_wdata
);

  logic [xlen-1:0] raw;

  // unmapped loads land on chan_none and read zero
  always_comb begin
    case (i_chan)
      chan_mem:   raw = i_mem_rdata;
      chan_clint: raw = i_clint_rdata;
      default:    raw = '0;
    endcase
  end

  always_comb begin
    case (i_opcode)
      op_lb:   o_rd_wdata = {{56{raw[7]}}, raw[7:0]};
      op_lbu:  o_rd_wdata = {56'd0, raw[7:0]};
      op_lh:   o_rd_wdata = {{48{raw[15]}}, raw[15:0]};
      op_lhu:  o_rd_wdata = {48'd0, raw[15:0]};
      op_lw:   o_rd_wdata = {{32{raw[31]}}, raw[31:0]};
      op_lwu:  o_rd_wdata = {32'd0, raw[31:0]};
      op_ld:   o_rd_wdata = raw;
      default: o_rd_wdata = i_rd_wdata;
    endcase
  end

endmodule

// ==== logic/mem_stage.sv ====
// Memory-access stage with one instruction in flight
// Upstream is acked only while idle; outputs hold until the downstream ack
`timescale 1ns/1ps

module mem_stage import mem_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  // executed side
  input  logic                i_executed_req,
  output logic                o_executed_ack,
  input  logic [xlen-1:0]     i_pc,
  input  logic [31:0]         i_inst,
  input  logic [ridx_w-1:0]   i_rd,
  input  logic                i_rd_wen,
  input  logic [xlen-1:0]     i_rd_wdata,
  input  logic                i_nocmt,
  input  logic                i_skipcmt,
  input  logic [opcode_w-1:0] i_opcode,
  input  logic [xlen-1:0]     i_op1,
  input  logic [xlen-1:0]     i_op2,
  input  logic [xlen-1:0]     i_op3,
  input  logic [31:0]         i_intr_no,
  // memoryed side
  output logic                o_memoryed_req,
  input  logic                i_memoryed_ack,
  output logic [xlen-1:0]     o_pc,
  output logic [31:0]         o_inst,
  output logic [ridx_w-1:0]   o_rd,
  output logic                o_rd_wen,
  output logic [xlen-1:0]     o_rd_wdata,
  output logic                o_nocmt,
  output logic                o_skipcmt,
  output logic [31:0]         o_intr_no,
  output logic                o_clint_overflow,
  // fence.i handshake
  output logic                o_fencei_req,
  input  logic                i_fencei_ack,
  // data cache
  output logic                o_dcache_req,
  output logic [xlen-1:0]     o_dcache_addr,
  output logic                o_dcache_op,
  output logic [bytes_w-1:0]  o_dcache_bytes,
  output logic [xlen-1:0]     o_dcache_wdata,
  input  logic                i_dcache_ack,
  input  logic [xlen-1:0]     i_dcache_rdata
);

  logic                executed_hs;
  logic                memoryed_hs;
  logic [xlen-1:0]     addr;
  logic [bytes_w-1:0]  bytes;
  logic                ren;
  logic                wen;
  logic [xlen-1:0]     wdata;
  logic [chan_w-1:0]   chan;
  logic                busy;
  logic [chan_w-1:0]   chan_q;
  logic [opcode_w-1:0] opcode_q;
  logic [xlen-1:0]     rd_wdata_q;
  logic                skipcmt_q;
  logic                mem_done;
  logic [xlen-1:0]     mem_rdata;
  logic [xlen-1:0]     clint_rdata;
  logic                imm_done_q;
  logic                fencei_done_q;
  logic                cmpl;
  logic                resp_hold_q;

  assign o_executed_ack = !busy;
  assign executed_hs    = i_executed_req && o_executed_ack;
  assign memoryed_hs    = o_memoryed_req && i_memoryed_ack;

  mem_addr_gen addr_gen_inst (
    .i_opcode (i_opcode),
    .i_op1    (i_op1),
    .i_op2    (i_op2),
    .i_op3    (i_op3),
    .o_addr   (addr),
    .o_bytes  (bytes),
    .o_ren    (ren),
    .o_wen    (wen),
    .o_wdata  (wdata),
    .o_chan   (chan)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      chan_q <= chan_none;
    end else if (executed_hs) begin
      busy   <= 1'b1;
      chan_q <= chan;
    end else if (memoryed_hs) begin
      busy   <= 1'b0;
      chan_q <= chan_none;
    end
  end

  // writeback fields of the held instruction
  always_ff @(posedge clk) begin
    if (executed_hs) begin
      o_pc       <= i_pc;
      o_inst     <= i_inst;
      o_rd       <= i_rd;
      o_rd_wen   <= i_rd_wen;
      rd_wdata_q <= i_rd_wdata;
      o_nocmt    <= i_nocmt;
      skipcmt_q  <= i_skipcmt;
      opcode_q   <= i_opcode;
      o_intr_no  <= i_intr_no;
    end
  end

  // difftest cannot model CLINT side effects
  assign o_skipcmt = skipcmt_q || (chan_q == chan_clint);

  mem_dcache_port dcache_port_inst (
    .clk            (clk),
    .rst            (rst),
    .i_start        (executed_hs && (chan == chan_mem)),
    .i_addr         (addr),
    .i_bytes        (bytes),
    .i_wen          (wen),
    .i_wdata        (wdata),
    .i_dcache_ack   (i_dcache_ack),
    .i_dcache_rdata (i_dcache_rdata),
    .o_done         (mem_done),
    .o_rdata        (mem_rdata),
    .o_dcache_req   (o_dcache_req),
    .o_dcache_addr  (o_dcache_addr),
    .o_dcache_op    (o_dcache_op),
    .o_dcache_bytes (o_dcache_bytes),
    .o_dcache_wdata (o_dcache_wdata)
  );

  mem_clint clint_inst (
    .clk        (clk),
    .rst        (rst),
    .i_start    (executed_hs && (chan == chan_clint)),
    .i_addr     (addr),
    .i_ren      (ren),
    .i_wen      (wen),
    .i_wdata    (wdata),
    .o_rdata    (clint_rdata),
    .o_overflow (o_clint_overflow)
  );

  // fence.i request until the cache reports sync done
  always_ff @(posedge clk) begin
    if (rst) begin
      o_fencei_req  <= 1'b0;
      fencei_done_q <= 1'b0;
    end else begin
      fencei_done_q <= o_fencei_req && i_fencei_ack;
      if (executed_hs && (chan == chan_sync)) begin
        o_fencei_req <= 1'b1;
      end else if (i_fencei_ack) begin
        o_fencei_req <= 1'b0;
      end
    end
  end

  // none and clint both finish one cycle after acceptance
  always_ff @(posedge clk) begin
    if (rst) begin
      imm_done_q <= 1'b0;
    end else begin
      imm_done_q <= executed_hs && ((chan == chan_none) || (chan == chan_clint));
    end
  end

  always_comb begin
    case (chan_q)
      chan_mem:  cmpl = mem_done;
      chan_sync: cmpl = fencei_done_q;
      default:   cmpl = imm_done_q;
    endcase
  end

  // completion is a pulse, keep req up under back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_hold_q <= 1'b0;
    end else if (memoryed_hs) begin
      resp_hold_q <= 1'b0;
    end else if (cmpl) begin
      resp_hold_q <= 1'b1;
    end
  end

  assign o_memoryed_req = cmpl || resp_hold_q;

  mem_load_align load_align_inst (
    .i_opcode      (opcode_q),
    .i_chan        (chan_q),
    .i_mem_rdata   (mem_rdata),
    .i_clint_rdata (clint_rdata),
    .i_rd_wdata    (rd_wdata_q),
    .o_rd_wdata    (o_rd_wdata)
  );

endmodule

// ==== testbench/mem_stage_properties.sv ====
// Handshake rules of mem_stage, bound into the DUT
// Checks are off while reset is high
`timescale 1ns/1ps

module mem_stage_properties (
  input logic clk,
  input logic rst,
  input logic i_dcache_req,
  input logic i_dcache_ack,
  input logic i_memoryed_req,
  input logic i_memoryed_ack,
  input logic i_executed_ack
);

  int fail_count = 0;

  property hold_until_ack(req, ack);
    @(posedge clk) disable iff (rst) (req && !ack) |=> req;
  endproperty

  dcache_req_hold: assert property (hold_until_ack(i_dcache_req, i_dcache_ack))
    else begin
      fail_count++;
      $error("dcache request dropped before its acknowledge");
    end

  memoryed_req_hold: assert property (hold_until_ack(i_memoryed_req, i_memoryed_ack))
    else begin
      fail_count++;
      $error("memoryed request dropped before its acknowledge");
    end

  // one instruction in flight
  idle_excl: assert property (@(posedge clk) disable iff (rst)
    !(i_executed_ack && i_memoryed_req))
    else begin
      fail_count++;
      $error("upstream acked while a response is pending");
    end

endmodule

// ==== testbench/tb_mem_stage.sv ====
// Self-checking testbench with data-cache, FENCE.I and downstream models
// mtime is never read back since its value depends on elapsed cycles
`timescale 1ns/1ps

module tb_mem_stage
  import mem_pkg::*;
  import clint_pkg::*;
();

  logic clk = 1'b0;
  logic rst;
  logic i_executed_req, i_rd_wen, i_nocmt, i_skipcmt;
  logic i_memoryed_ack, i_fencei_ack, i_dcache_ack;
  logic [xlen-1:0] i_pc, i_rd_wdata, i_op1, i_op2, i_op3, i_dcache_rdata;
  logic [31:0] i_inst, i_intr_no;
  logic [ridx_w-1:0] i_rd;
  logic [opcode_w-1:0] i_opcode;
  logic o_executed_ack, o_memoryed_req, o_rd_wen, o_nocmt, o_skipcmt;
  logic o_clint_overflow, o_fencei_req, o_dcache_req, o_dcache_op;
  logic [xlen-1:0] o_pc, o_rd_wdata, o_dcache_addr, o_dcache_wdata;
  logic [31:0] o_inst, o_intr_no;
  logic [ridx_w-1:0] o_rd;
  logic [bytes_w-1:0] o_dcache_bytes;

  logic [31:0] lcg_state = 32'h0b9a_4d29;
  logic [xlen-1:0] mem_model [logic [xlen-1:0]];
  logic [xlen-1:0] exp_data_q[$];
  logic [xlen-1:0] exp_pc_q[$];
  logic [ridx_w-1:0] exp_rd_q[$];
  logic [31:0] exp_intr_q[$];
  logic [31:0] exp_inst_q[$];
  logic [1:0] exp_flags_q[$];
  logic exp_skip_q[$];
  logic [xlen-1:0] exp_addr, exp_wdata;
  logic [bytes_w-1:0] exp_bytes;
  logic exp_op;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int err_mark = 0;
  int dcache_count = 0;
  int fence_count = 0;
  int min_hold = 0;
  string cur_test = "none";

  always #5 clk = ~clk;

  bind mem_stage mem_stage_properties props_inst (
    .clk            (clk),
    .rst            (rst),
    .i_dcache_req   (o_dcache_req),
    .i_dcache_ack   (i_dcache_ack),
    .i_memoryed_req (o_memoryed_req),
    .i_memoryed_ack (i_memoryed_ack),
    .i_executed_ack (o_executed_ack)
  );

  mem_stage mem_stage_inst (.*);

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  function automatic logic [3:0] access_bytes(input logic [opcode_w-1:0] op);
    case (op)
      op_lb, op_lbu, op_sb: return 4'd1;
      op_lh, op_lhu, op_sh: return 4'd2;
      op_lw, op_lwu, op_sw: return 4'd4;
      op_ld, op_sd:         return 4'd8;
      default:              return 4'd0;
    endcase
  endfunction

  function automatic logic is_load(input logic [opcode_w-1:0] op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  // unwritten doublewords read back a pattern of their address
  function automatic logic [xlen-1:0] mem_read(input logic [xlen-1:0] addr);
    if (mem_model.exists(addr)) begin
      return mem_model[addr];
    end
    return addr * 64'h9e37_79b9_7f4a_7c15;
  endfunction

  // expected writeback value
  function automatic logic [xlen-1:0] ref_rd_wdata(input logic [opcode_w-1:0] op,
                                                   input logic [xlen-1:0] raw,
                                                   input logic [xlen-1:0] rdw);
    int sh;
    sh = 64 - 8 * int'(access_bytes(op));
    if (!is_load(op)) begin
      return rdw;
    end
    if (op inside {op_lb, op_lh, op_lw, op_ld}) begin
      return $signed(raw << sh) >>> sh;
    end
    return (raw << sh) >> sh;
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("ERROR %s: %s", cur_test, msg);
    end
  endtask

  task automatic abort(input string msg);
    $display("ERROR %s: %s", cur_test, msg);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == err_mark) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - err_mark);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!o_executed_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 100) begin
        abort("timeout waiting for the stage to go idle");
      end
    end
  endtask

  // one instruction from acceptance to retirement
  task automatic issue(input logic [opcode_w-1:0] op, input logic [xlen-1:0] op1,
                       input logic [xlen-1:0] op2, input logic [xlen-1:0] op3,
                       input logic [xlen-1:0] raw, input logic is_clint);
    logic [31:0] r;
    int sh;
    r = next_rand();
    sh = 64 - 8 * int'(access_bytes(op));
    exp_addr = op1 + op3;
    exp_op = !is_load(op);
    exp_bytes = 3'(access_bytes(op) - 4'd1);
    exp_wdata = (op2 << sh) >> sh;
    wait_idle();
    i_opcode = op;
    i_op1 = op1;
    i_op2 = op2;
    i_op3 = op3;
    i_rd_wdata = {next_rand(), next_rand()};
    i_pc = {32'd0, next_rand()};
    i_inst = next_rand();
    i_intr_no = next_rand();
    i_rd = r[4:0];
    i_rd_wen = r[5];
    i_nocmt = r[6];
    i_skipcmt = r[7];
    exp_data_q.push_back(ref_rd_wdata(op, raw, i_rd_wdata));
    exp_pc_q.push_back(i_pc);
    exp_rd_q.push_back(i_rd);
    exp_intr_q.push_back(i_intr_no);
    exp_inst_q.push_back(i_inst);
    exp_flags_q.push_back({i_rd_wen, i_nocmt});
    exp_skip_q.push_back(i_skipcmt || is_clint);
    i_executed_req = 1'b1;
    @(posedge clk);
    #1;
    i_executed_req = 1'b0;
    wait_idle();
  endtask

  task automatic compare_response();
    if (exp_data_q.size() == 0) begin
      check_true(1'b0, "response without a pending instruction");
    end else begin
      check_val("rd_wdata", exp_data_q.pop_front(), o_rd_wdata);
      check_val("pc", exp_pc_q.pop_front(), o_pc);
      check_val("rd", 64'(exp_rd_q.pop_front()), 64'(o_rd));
      check_val("intr_no", 64'(exp_intr_q.pop_front()), 64'(o_intr_no));
      check_val("inst", 64'(exp_inst_q.pop_front()), 64'(o_inst));
      check_val("rd_wen and nocmt", 64'(exp_flags_q.pop_front()), 64'({o_rd_wen, o_nocmt}));
      check_val("skipcmt", 64'(exp_skip_q.pop_front()), 64'(o_skipcmt));
    end
  endtask

  initial begin : dcache_model
    int delay;
    logic [xlen-1:0] word;
    forever begin
      @(posedge clk);
      #1;
      if (o_dcache_req && !i_dcache_ack) begin
        dcache_count++;
        check_val("dcache addr", exp_addr, o_dcache_addr);
        check_val("dcache op", 64'(exp_op), 64'(o_dcache_op));
        check_val("dcache bytes", 64'(exp_bytes), 64'(o_dcache_bytes));
        if (o_dcache_op) begin
          check_val("dcache wdata", exp_wdata, o_dcache_wdata);
        end
        delay = int'(next_rand() % 4);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        word = mem_read(o_dcache_addr);
        i_dcache_rdata = word;
        if (o_dcache_op) begin
          for (int b = 0; b < 8; b++) begin
            if (b <= int'(o_dcache_bytes)) begin
              word[8*b +: 8] = o_dcache_wdata[8*b +: 8];
            end
          end
          mem_model[o_dcache_addr] = word;
        end
        i_dcache_ack = 1'b1;
        @(posedge clk);
        #1;
        i_dcache_ack = 1'b0;
      end
    end
  end

  initial begin : fence_model
    int delay;
    forever begin
      @(posedge clk);
      #1;
      if (o_fencei_req && !i_fencei_ack) begin
        fence_count++;
        delay = 1 + int'(next_rand() % 3);
        repeat (delay) begin
          @(posedge clk);
          #1;
          check_true(!o_memoryed_req, "fence.i completed before its acknowledge");
        end
        i_fencei_ack = 1'b1;
        @(posedge clk);
        #1;
        i_fencei_ack = 1'b0;
      end
    end
  end

  // downstream with random back-pressure
  initial begin : downstream_model
    int hold;
    logic [xlen-1:0] snap_pc;
    logic [xlen-1:0] snap_data;
    logic [ridx_w-1:0] snap_rd;
    logic [31:0] snap_intr;
    logic [34:0] snap_misc;
    forever begin
      @(posedge clk);
      #1;
      if (o_memoryed_req && !i_memoryed_ack) begin
        hold = min_hold + int'(next_rand() % 4);
        snap_pc = o_pc;
        snap_data = o_rd_wdata;
        snap_rd = o_rd;
        snap_intr = o_intr_no;
        snap_misc = {o_inst, o_rd_wen, o_nocmt, o_skipcmt};
        repeat (hold) begin
          @(posedge clk);
          #1;
          check_true(o_memoryed_req && !o_executed_ack, "response not held under back-pressure");
          check_val("held pc", snap_pc, o_pc);
          check_val("held rd_wdata", snap_data, o_rd_wdata);
          check_val("held rd", 64'(snap_rd), 64'(o_rd));
          check_val("held intr_no", 64'(snap_intr), 64'(o_intr_no));
          check_val("held inst and flags", 64'(snap_misc),
                    64'({o_inst, o_rd_wen, o_nocmt, o_skipcmt}));
        end
        compare_response();
        i_memoryed_ack = 1'b1;
        @(posedge clk);
        #1;
        i_memoryed_ack = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [opcode_w-1:0] stores [4];
    logic [opcode_w-1:0] loads [7];
    logic [xlen-1:0] base;
    logic [xlen-1:0] off;
    int cnt;
    stores = '{op_sb, op_sh, op_sw, op_sd};
    loads = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
    base = 64'h0000_0001_8000_0ff8;
    rst = 1'b1;
    i_executed_req = 1'b0;
    i_memoryed_ack = 1'b0;
    i_fencei_ack = 1'b0;
    i_dcache_ack = 1'b0;
    i_dcache_rdata = '0;
    i_pc = '0;
    i_inst = '0;
    i_rd = '0;
    i_rd_wen = 1'b0;
    i_rd_wdata = '0;
    i_nocmt = 1'b0;
    i_skipcmt = 1'b0;
    i_opcode = '0;
    i_op1 = '0;
    i_op2 = '0;
    i_op3 = '0;
    i_intr_no = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("reset");
    check_true(!o_clint_overflow, "timer overflow high after reset");
    check_true(o_executed_ack && !o_memoryed_req, "stage not idle after reset");
    check_true(!o_dcache_req && !o_fencei_req, "request raised during reset");
    end_test();

    begin_test("mem_store_load");
    for (int i = 0; i < 36; i++) begin
      off = 64'(8 * (next_rand() % 6));
      if (i < 16) begin
        issue(stores[i % 4], base, {next_rand(), next_rand()}, off, 64'd0, 1'b0);
      end else begin
        issue(loads[i % 7], base, 64'd0, off, mem_read(base + off), 1'b0);
      end
    end
    end_test();

    begin_test("no_access");
    cnt = dcache_count;
    issue(8'h05, base, 64'd1, 64'd8, 64'd0, 1'b0);
    issue(op_ld, 64'h0000_1000, 64'd0, 64'd8, 64'd0, 1'b0);
    check_val("dcache requests", 64'(cnt), 64'(dcache_count));
    end_test();

    begin_test("clint");
    check_true(!o_clint_overflow, "timer overflow high before mtimecmp is written");
    issue(op_ld, 64'(clint_mtimecmp_addr), 64'd0, 64'd0, clint_mtimecmp_reset, 1'b1);
    issue(op_sd, 64'h0200_0000, 64'h20, 64'(clint_mtimecmp_addr) - 64'h0200_0000,
          64'd0, 1'b1);
    check_true(o_clint_overflow, "timer overflow low with mtimecmp below mtime");
    issue(op_ld, 64'h0200_0000, 64'd0, 64'h4000, 64'h20, 1'b1);
    // mapped prefix but no register there
    issue(op_lw, 64'h0200_0000, 64'd0, 64'h10, 64'd0, 1'b1);
    end_test();

    begin_test("fencei");
    cnt = fence_count;
    issue(op_fencei, base, 64'd0, 64'd0, 64'd0, 1'b0);
    check_val("fence requests", 64'(cnt + 1), 64'(fence_count));
    end_test();

    begin_test("backpressure");
    min_hold = 5;
    issue(op_lh, base, 64'd0, 64'd16, mem_read(base + 64'd16), 1'b0);
    issue(op_ld, 64'h0200_0000, 64'd0, 64'h4000, 64'h20, 1'b1);
    issue(op_fencei, base, 64'd0, 64'd0, 64'd0, 1'b0);
    min_hold = 0;
    end_test();

    errors += mem_stage_inst.props_inst.fail_count;
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/mem_pkg.sv
logic/clint_pkg.sv
logic/mem_addr_gen.sv
logic/mem_dcache_port.sv
logic/mem_clint.sv
logic/mem_load_align.sv
logic/mem_stage.sv
testbench/mem_stage_properties.sv
testbench/tb_mem_stage.sv
